/* common/size_principle_pkg.sv */
package size_principle_pkg;

    // pool size
    localparam int NUM_NEURONS = 8;
    localparam int NEURON_ID_W = $clog2(NUM_NEURONS);
    localparam int MEMBRANE_W  = 18;

    typedef logic [15:0]             length_t;
    typedef logic [15:0]             drive_t;
    typedef logic [MEMBRANE_W-1:0]   membrane_t;
    typedef logic [15:0]             param_t;
    typedef logic [2:0]              param_addr_t;
    typedef logic [15:0]             count_t;
    typedef logic [NEURON_ID_W-1:0]  neuron_id_t;

    // fractional bits of the gain register
    localparam int GAIN_FRAC = 4;

    ////////////////////////////////////////////////////////////
    // register map
    localparam param_addr_t ADDR_GAIN        = 3'd0;
    localparam param_addr_t ADDR_REST_LEN    = 3'd1;
    localparam param_addr_t ADDR_LEAK_SHIFT  = 3'd2;
    localparam param_addr_t ADDR_THRESH_BASE = 3'd3;
    localparam param_addr_t ADDR_THRESH_STEP = 3'd4;
    localparam param_addr_t ADDR_WINDOW_LEN  = 3'd5;

    ////////////////////////////////////////////////////////////
    // values after reset, gain of 16 is unity
    localparam param_t DEF_GAIN        = 16'd16;
    localparam param_t DEF_REST_LEN    = 16'd1000;
    localparam param_t DEF_LEAK_SHIFT  = 16'd4;
    localparam param_t DEF_THRESH_BASE = 16'd2000;
    localparam param_t DEF_THRESH_STEP = 16'd500;
    localparam param_t DEF_WINDOW_LEN  = 16'd64;

endpackage

/* common/drive_if.sv */
`timescale 1ns/1ns

// afferent drive plus the settings every neuron needs
interface drive_if
    import size_principle_pkg::*;
();

    drive_t drive;
    param_t leak_shift;
    param_t thresh_base;
    param_t thresh_step;

    modport source (
        output drive,
        output leak_shift,
        output thresh_base,
        output thresh_step
    );

    modport sink (
        input drive,
        input leak_shift,
        input thresh_base,
        input thresh_step
    );

endinterface

/* src/param_regs.sv */
`timescale 1ns/1ns

module param_regs
    import size_principle_pkg::*;
(
    input  logic        i_ep50trig,
    input  logic        i_reset_global,

    // host write strobe
    input  logic        i_param_write,
    input  param_addr_t i_param_addr,
    input  param_t      i_param_data,

    // register values
    output param_t      o_gain,
    output param_t      o_rest_len,
    output param_t      o_leak_shift,
    output param_t      o_thresh_base,
    output param_t      o_thresh_step,
    output param_t      o_window_len
);

    ////////////////////////////////////////////////////////////
    // one register per address, loaded on the strobe edge
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_gain        <= DEF_GAIN;
            o_rest_len    <= DEF_REST_LEN;
            o_leak_shift  <= DEF_LEAK_SHIFT;
            o_thresh_base <= DEF_THRESH_BASE;
            o_thresh_step <= DEF_THRESH_STEP;
            o_window_len  <= DEF_WINDOW_LEN;
        end
        else if (i_param_write)
        begin
            case (i_param_addr)
                ADDR_GAIN:
                    o_gain <= i_param_data;
                ADDR_REST_LEN:
                    o_rest_len <= i_param_data;
                ADDR_LEAK_SHIFT:
                    o_leak_shift <= i_param_data;
                ADDR_THRESH_BASE:
                    o_thresh_base <= i_param_data;
                ADDR_THRESH_STEP:
                    o_thresh_step <= i_param_data;
                ADDR_WINDOW_LEN:
                    o_window_len <= i_param_data;
                // addresses 6 and 7 are unmapped
                default:
                begin
                end
            endcase
        end
    end

endmodule

/* afferent/afferent_drive.sv */
`timescale 1ns/1ns

module afferent_drive
    import size_principle_pkg::*;
(
    input  logic    i_ep50trig,
    input  logic    i_reset_global,
    input  length_t i_length,
    input  param_t  i_gain,
    input  param_t  i_rest_len,
    input  param_t  i_leak_shift,
    input  param_t  i_thresh_base,
    input  param_t  i_thresh_step,
    drive_if.source o_drive_bus
);

    length_t     stretch;
    logic [31:0] scaled;
    drive_t      drive_sat;
    drive_t      drive_q;

    ////////////////////////////////////////////////////////////
    // stretch above rest, times gain in 12.4 format
    always_comb
    begin
        if (i_length > i_rest_len)
            stretch = i_length - i_rest_len;
        else
            stretch = '0;

        scaled = (32'(stretch) * 32'(i_gain)) >> GAIN_FRAC;

        // clip to the largest drive
        if (|scaled[31:$bits(drive_t)])
            drive_sat = '1;
        else
            drive_sat = scaled[$bits(drive_t)-1:0];
    end

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            drive_q <= '0;
        else
            drive_q <= drive_sat;
    end

    // one bundle toward the pool
    assign o_drive_bus.drive       = drive_q;
    assign o_drive_bus.leak_shift  = i_leak_shift;
    assign o_drive_bus.thresh_base = i_thresh_base;
    assign o_drive_bus.thresh_step = i_thresh_step;

endmodule

/* pool/motor_neuron.sv */
`timescale 1ns/1ns

module motor_neuron
    import size_principle_pkg::*;
#(
    parameter int NEURON_INDEX = 0
)
(
    input  logic  i_ep50trig,
    input  logic  i_reset_global,
    drive_if.sink i_drive_bus,
    output logic  o_spike
);

    membrane_t             potential;
    membrane_t             leak;
    logic [MEMBRANE_W:0]   integ;
    membrane_t             potential_next;
    logic [31:0]           threshold;

    // size principle: higher index, higher threshold
    assign threshold = 32'(i_drive_bus.thresh_base)
                     + 32'(NEURON_INDEX) * 32'(i_drive_bus.thresh_step);

    ////////////////////////////////////////////////////////////
    // leaky integration with saturation
    assign leak  = potential >> i_drive_bus.leak_shift;
    assign integ = (MEMBRANE_W+1)'(potential - leak)
                 + (MEMBRANE_W+1)'(i_drive_bus.drive);

    assign potential_next = integ[MEMBRANE_W] ? '1 : integ[MEMBRANE_W-1:0];

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            potential <= '0;
            o_spike   <= 1'b0;
        end
        else if (32'(potential) >= threshold)
        begin
            // fire and start over from rest
            potential <= '0;
            o_spike   <= 1'b1;
        end
        else
        begin
            potential <= potential_next;
            o_spike   <= 1'b0;
        end
    end

endmodule

/* pool/spike_collector.sv */
`timescale 1ns/1ns

module spike_collector
    import size_principle_pkg::*;
(
    input  logic                   i_ep50trig,
    input  logic                   i_reset_global,
    input  logic [NUM_NEURONS-1:0] i_spikes,
    input  param_t                 i_window_len,
    output logic                   o_spike_valid,
    output neuron_id_t             o_spike_id,
    output logic                   o_count_valid,
    output count_t                 o_spike_count
);

    neuron_id_t            lowest_id;
    count_t                spike_total;
    count_t                acc;
    logic [$bits(count_t):0] acc_sum;
    count_t                acc_sat;
    param_t                win_cnt;
    param_t                win_len;

    ////////////////////////////////////////////////////////////
    // priority pick and population count
    always_comb
    begin
        lowest_id   = '0;
        spike_total = '0;
        for (int i = NUM_NEURONS - 1; i >= 0; i--)
        begin
            if (i_spikes[i])
                lowest_id = neuron_id_t'(i);
        end
        for (int i = 0; i < NUM_NEURONS; i++)
            spike_total = spike_total + count_t'(i_spikes[i]);
    end

    // count sticks at full scale
    assign acc_sum = {1'b0, acc} + {1'b0, spike_total};
    assign acc_sat = acc_sum[$bits(count_t)] ? '1 : acc_sum[$bits(count_t)-1:0];

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_spike_valid <= 1'b0;
            o_spike_id    <= '0;
            o_count_valid <= 1'b0;
            o_spike_count <= '0;
            acc           <= '0;
            win_cnt       <= '0;
            win_len       <= DEF_WINDOW_LEN;
        end
        else
        begin
            o_spike_valid <= |i_spikes;
            o_spike_id    <= lowest_id;
            o_count_valid <= 1'b0;
            if (win_cnt == win_len - 1'b1)
            begin
                // close window, new length applies from here
                o_spike_count <= acc_sat;
                o_count_valid <= 1'b1;
                acc           <= '0;
                win_cnt       <= '0;
                win_len       <= i_window_len;
            end
            else
            begin
                acc     <= acc_sat;
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

endmodule

/* src/size_principle_top.sv */
`timescale 1ns/1ns

module size_principle_top
    import size_principle_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_param_write,
    input  param_addr_t i_param_addr,
    input  param_t      i_param_data,
    input  length_t     i_length,
    output logic        o_spike_valid,
    output neuron_id_t  o_spike_id,
    output logic        o_count_valid,
    output count_t      o_spike_count
);

    param_t gain;
    param_t rest_len;
    param_t leak_shift;
    param_t thresh_base;
    param_t thresh_step;
    param_t window_len;

    logic [NUM_NEURONS-1:0] spikes;

    drive_if u_drive_bus ();

    ////////////////////////////////////////////////////////////
    // host registers
    param_regs u_param_regs (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_param_write  (i_param_write),
        .i_param_addr   (i_param_addr),
        .i_param_data   (i_param_data),
        .o_gain         (gain),
        .o_rest_len     (rest_len),
        .o_leak_shift   (leak_shift),
        .o_thresh_base  (thresh_base),
        .o_thresh_step  (thresh_step),
        .o_window_len   (window_len)
    );

    afferent_drive u_afferent (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_length       (i_length),
        .i_gain         (gain),
        .i_rest_len     (rest_len),
        .i_leak_shift   (leak_shift),
        .i_thresh_base  (thresh_base),
        .i_thresh_step  (thresh_step),
        .o_drive_bus    (u_drive_bus.source)
    );

    ////////////////////////////////////////////////////////////
    // motor neuron pool, thresholds ordered by index
    for (genvar k = 0; k < NUM_NEURONS; k++)
    begin : g_neuron
        motor_neuron #(
            .NEURON_INDEX (k)
        ) u_neuron (
            .i_ep50trig     (ep50trig),
            .i_reset_global (reset_global),
            .i_drive_bus    (u_drive_bus.sink),
            .o_spike        (spikes[k])
        );
    end

    spike_collector u_collector (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_spikes       (spikes),
        .i_window_len   (window_len),
        .o_spike_valid  (o_spike_valid),
        .o_spike_id     (o_spike_id),
        .o_count_valid  (o_count_valid),
        .o_spike_count  (o_spike_count)
    );

endmodule

/* sim/size_principle_properties.sv */
`timescale 1ns/1ns

module size_principle_properties
    import size_principle_pkg::*;
(
    input logic       i_ep50trig,
    input logic       i_reset_global,
    input logic       i_spike_valid,
    input neuron_id_t i_spike_id,
    input logic       i_count_valid,
    input count_t     i_spike_count
);

    ////////////////////////////////////////////////////////////
    // outputs quiet in the cycle after reset
    a_reset_quiet: assert property (@(posedge i_ep50trig)
        i_reset_global |=> !i_spike_valid && !i_count_valid)
        else $error("valid output high in the cycle after reset");

    // window pulse lasts one cycle
    a_count_pulse: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        i_count_valid |=> !i_count_valid)
        else $error("count valid held longer than one cycle");

    // count holds between window pulses
    a_count_hold: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        !i_count_valid |-> $stable(i_spike_count))
        else $error("spike count changed without a count valid pulse");

endmodule

/* sim/tb_size_principle.sv */
`timescale 1ns/1ns

module tb_size_principle
    import size_principle_pkg::*;
();

    typedef enum int {PH_SILENCE, PH_FREE, PH_SINGLE} phase_e;

    logic        ep50trig;
    logic        reset_global;
    logic        i_param_write;
    param_addr_t i_param_addr;
    param_t      i_param_data;
    length_t     i_length;
    logic        o_spike_valid;
    neuron_id_t  o_spike_id;
    logic        o_count_valid;
    count_t      o_spike_count;

    phase_e phase = PH_SILENCE;
    integer seed = 32'h4a6;
    int     next_win = int'(DEF_WINDOW_LEN);
    int     cur_win;
    int     gap_cnt;
    logic   seen_pulse;
    logic   prev_count_valid;
    logic   first_spike_seen;
    int     mon_errors = 0;
    int     seq_errors = 0;
    int     err_mark = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     small_s;
    int     large_s;
    int     count_small;
    int     count_large;

    size_principle_top u_dut (.*);

    bind size_principle_top size_principle_properties u_props (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_spike_valid  (o_spike_valid),
        .i_spike_id     (o_spike_id),
        .i_count_valid  (o_count_valid),
        .i_spike_count  (o_spike_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #5 ep50trig = ~ep50trig;
    end

    task automatic flag_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        mon_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor sampled on the rising edge
    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            gap_cnt          <= 0;
            seen_pulse       <= 1'b0;
            prev_count_valid <= 1'b0;
            first_spike_seen <= 1'b0;
            cur_win          <= int'(DEF_WINDOW_LEN);
        end
        else
        begin
            prev_count_valid <= o_count_valid;
            assert (!(o_count_valid && prev_count_valid))
                else flag_error("count valid high on two cycles in a row");
            if (o_count_valid)
            begin
                if (seen_pulse)
                begin
                    assert (gap_cnt + 1 == cur_win)
                        else flag_error($sformatf("window gap %0d, expected %0d",
                                                  gap_cnt + 1, cur_win));
                end
                assert (int'(o_spike_count) <= NUM_NEURONS * cur_win)
                    else flag_error($sformatf("count %0d above pool bound", o_spike_count));
                if (phase == PH_SILENCE)
                begin
                    assert (o_spike_count == '0)
                        else flag_error($sformatf("count %0d at rest, expected 0",
                                                  o_spike_count));
                end
                if (phase == PH_SINGLE)
                begin
                    assert (int'(o_spike_count) <= cur_win)
                        else flag_error($sformatf("count %0d above window %0d",
                                                  o_spike_count, cur_win));
                end
                gap_cnt    <= 0;
                seen_pulse <= 1'b1;
                cur_win    <= next_win;
            end
            else
                gap_cnt <= gap_cnt + 1;

            if (o_spike_valid)
            begin
                if (!first_spike_seen)
                begin
                    first_spike_seen <= 1'b1;
                    assert (o_spike_id == '0)
                        else flag_error($sformatf("first spike id %0d, expected 0",
                                                  o_spike_id));
                end
                if (phase == PH_SINGLE)
                begin
                    assert (o_spike_id == '0)
                        else flag_error($sformatf("spike id %0d, expected 0", o_spike_id));
                end
            end
            if (phase == PH_SILENCE)
            begin
                assert (!o_spike_valid)
                    else flag_error("spike valid with zero drive");
            end
        end
    end

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #1;
    endtask

    task automatic write_param(input param_addr_t addr, input param_t data);
        i_param_write = 1'b1;
        i_param_addr  = addr;
        i_param_data  = data;
        @(posedge ep50trig);
        #1;
        i_param_write = 1'b0;
        if (addr == ADDR_WINDOW_LEN)
            next_win = int'(data);
    endtask

    task automatic wait_count_pulses(input int n, input int limit);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n)
        begin
            @(posedge ep50trig);
            cycles++;
            if (o_count_valid)
            begin
                seen++;
                cycles = 0;
            end
            else if (cycles > limit)
                abort_run("no window count pulse within the expected time");
        end
        #1;
    endtask

    task automatic wait_spike(input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found)
        begin
            @(posedge ep50trig);
            cycles++;
            if (o_spike_valid)
                found = 1'b1;
            else if (cycles > limit)
                abort_run("no spike seen after drive was applied");
        end
        #1;
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = mon_errors + seq_errors;
        if (now_errors == err_mark)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d check errors", name, now_errors - err_mark);
        end
        err_mark = now_errors;
    endtask

    task automatic hold_stretch(input int s, output int count);
        i_length = length_t'(int'(DEF_REST_LEN) + s);
        wait_count_pulses(3, 600);
        count = int'(o_spike_count);
    endtask

    ////////////////////////////////////////////////////////////
    // directed sequence
    initial
    begin
        reset_global  = 1'b1;
        i_param_write = 1'b0;
        i_param_addr  = '0;
        i_param_data  = '0;
        i_length      = DEF_REST_LEN - 16'd200;
        repeat (16) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // length below rest keeps the drive at zero
        wait_count_pulses(3, 200);
        end_test("test 1 reset and silence");

        wait_count_pulses(1, 200);
        idle_cycles(3);
        write_param(ADDR_WINDOW_LEN, 16'd32);
        wait_count_pulses(3, 200);
        end_test("test 2 window period");

        phase = PH_FREE;
        write_param(ADDR_LEAK_SHIFT, 16'hffff);
        i_length = length_t'(int'(DEF_REST_LEN) + 100);
        wait_spike(200);
        idle_cycles(2);
        end_test("test 3 recruitment order");

        // steady potential near 2400 clears only the neuron 0 threshold
        write_param(ADDR_THRESH_STEP, 16'd20000);
        write_param(ADDR_LEAK_SHIFT, 16'd4);
        i_length = length_t'(int'(DEF_REST_LEN) + 150);
        wait_count_pulses(2, 200);
        phase = PH_SINGLE;
        wait_spike(200);
        wait_count_pulses(3, 200);
        phase = PH_FREE;
        end_test("test 4 recruitment threshold");

        write_param(ADDR_THRESH_STEP, DEF_THRESH_STEP);
        write_param(ADDR_WINDOW_LEN, 16'd256);
        wait_count_pulses(2, 600);
        for (int pair = 0; pair < 4; pair++)
        begin
            small_s = 40 + ($random(seed) & 127);
            large_s = 2 * small_s + ($random(seed) & 63);
            hold_stretch(small_s, count_small);
            hold_stretch(large_s, count_large);
            assert (count_large >= count_small)
            else
            begin
                $display("ERROR %0t: stretch %0d gave count %0d below %0d from stretch %0d",
                         $time, large_s, count_large, count_small, small_s);
                seq_errors++;
            end
        end
        end_test("test 5 monotonic recruitment");

        // saturated drive makes the whole pool fire
        write_param(ADDR_GAIN, 16'hffff);
        i_length = 16'hffff;
        wait_count_pulses(3, 600);
        end_test("test 6 bounds");

        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 mon_errors + seq_errors);
        if (tests_failed == 0 && mon_errors + seq_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* src.f */
common/size_principle_pkg.sv
common/drive_if.sv
src/param_regs.sv
afferent/afferent_drive.sv
pool/motor_neuron.sv
pool/spike_collector.sv
src/size_principle_top.sv
sim/size_principle_properties.sv
sim/tb_size_principle.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_size_principle
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --assert --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
